// File: Makefile
VERILATOR ?= verilator
FLAGS     = --binary --timing
TOP       = dcache_tb
FILELIST  = src.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# Output is echoed and searched in memory, the status comes from grep
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF 'All tests passed!'

clean:
	rm -rf $(OBJ_DIR)

// File: rtl/dcache.sv
`timescale 1ns/1ps

module dcache import dcache_types_pkg::*, lsu_pkg::*; (
    input  logic     clk,
    input  logic     i_rst_n,
    input  dc_req_t  i_req,
    output dc_resp_t o_resp
);

    dc_index_t    rd_index;
    dc_stage0_t   stage0;
    dc_cache_rd_t cache_rd;
    dc_cache_wr_t cache_wr;

    // RAM read starts on the same edge that stage 0 latches the request
    assign rd_index = i_req.addr[DC_OFFSET_WIDTH +: DC_INDEX_WIDTH];

    dcache_d0 u_d0 (
        .clk      (clk),
        .i_rst_n  (i_rst_n),
        .i_req    (i_req),
        .o_stage0 (stage0)
    );

    dcache_d1 u_d1 (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_stage0   (stage0),
        .i_cache_rd (cache_rd),
        .o_cache_wr (cache_wr),
        .o_resp     (o_resp)
    );

    dcache_tag_ram u_tag_ram (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_rd_index (rd_index),
        .i_wr       (cache_wr),
        .o_rd       (cache_rd)
    );

endmodule

// File: rtl/dcache_d0.sv
`timescale 1ns/1ps

module dcache_d0 import dcache_types_pkg::*, lsu_pkg::*; (
    input  logic       clk,
    input  logic       i_rst_n,
    input  dc_req_t    i_req,
    output dc_stage0_t o_stage0
);

    dc_tag_t                  tag;
    dc_index_t                index;
    dc_offset_t               offset;
    logic                     store;
    logic [DC_WORD_BYTES-1:0] size_be;
    dc_line_t                 store_line;
    dc_line_t                 line_data;
    dc_line_be_t              line_be;

    assign {tag, index, offset} = i_req.addr;
    assign store = i_req.func inside {LSU_FUNC_SB, LSU_FUNC_SH, LSU_FUNC_SW};

    // Access size as a byte select, and the store data copied into every lane of that size
    always_comb begin
        case (i_req.func)
            LSU_FUNC_LB, LSU_FUNC_LBU, LSU_FUNC_SB: begin
                size_be    = 4'b0001;
                store_line = {DC_LINE_BYTES{i_req.data[7:0]}};
            end
            LSU_FUNC_LH, LSU_FUNC_LHU, LSU_FUNC_SH: begin
                size_be    = 4'b0011;
                store_line = {(DC_LINE_BYTES/2){i_req.data[15:0]}};
            end
            default: begin
                size_be    = 4'b1111;
                store_line = {DC_LINE_WORDS{i_req.data}};
            end
        endcase
    end

    // A fill replaces the whole line
    assign line_data = i_req.fill ? i_req.fill_data : store_line;
    assign line_be   = i_req.fill ? '1 : (dc_line_be_t'(size_be) << offset);

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_stage0 <= '0;
        end else begin
            o_stage0.valid  <= i_req.valid;
            o_stage0.store  <= store;
            o_stage0.fill   <= i_req.fill;
            o_stage0.func   <= i_req.func;
            o_stage0.tag    <= tag;
            o_stage0.index  <= index;
            o_stage0.offset <= offset;
            o_stage0.data   <= line_data;
            o_stage0.be     <= line_be;
            o_stage0.dirty  <= i_req.fill_dirty;
        end
    end

    a_half_aligned: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_req.valid && !i_req.fill && (i_req.func inside {LSU_FUNC_LH, LSU_FUNC_LHU, LSU_FUNC_SH})
        |-> i_req.addr[0] == 1'b0)
        else $error("Misaligned halfword access");

    a_word_aligned: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_req.valid && !i_req.fill && (i_req.func inside {LSU_FUNC_LW, LSU_FUNC_SW})
        |-> i_req.addr[1:0] == 2'b00)
        else $error("Misaligned word access");

    a_fill_not_store: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_req.valid && i_req.fill |-> !store)
        else $error("Fill request carries a store function");

endmodule

// File: rtl/dcache_d1.sv
`timescale 1ns/1ps

module dcache_d1 import dcache_types_pkg::*, lsu_pkg::*; (
    input  logic         clk,
    input  logic         i_rst_n,
    input  dc_stage0_t   i_stage0,
    input  dc_cache_rd_t i_cache_rd,
    output dc_cache_wr_t o_cache_wr,
    output dc_resp_t     o_resp
);

    lsu_func_e    func;
    logic         bypass;
    logic         eff_valid;
    logic         eff_dirty;
    dc_tag_t      eff_tag;
    dc_line_t     eff_data;
    logic         hit;
    logic         is_load;
    logic         victim_valid;
    dc_word_t     ld_word;
    logic [7:0]   ld_byte;
    logic [15:0]  ld_half;
    dc_word_t     load_data;
    dc_cache_wr_t wr_d;
    dc_resp_t     resp_d;

    assign func    = lsu_func_e'(i_stage0.func);
    assign is_load = !i_stage0.store && !i_stage0.fill;

    // The RAM was read before our own pending write landed, so lay that write over it
    assign bypass    = o_cache_wr.en && (o_cache_wr.index == i_stage0.index);
    assign eff_valid = bypass ? o_cache_wr.valid : i_cache_rd.valid;
    assign eff_dirty = bypass ? o_cache_wr.dirty : i_cache_rd.dirty;
    assign eff_tag   = bypass ? o_cache_wr.tag : i_cache_rd.tag;
    assign eff_data  = bypass ? dc_merge_line(i_cache_rd.data, o_cache_wr.data, o_cache_wr.be)
                              : i_cache_rd.data;

    assign hit = eff_valid && (eff_tag == i_stage0.tag);

    assign ld_word = eff_data[{i_stage0.offset[DC_OFFSET_WIDTH-1:2], 5'b00000} +: 32];
    assign ld_byte = ld_word[{i_stage0.offset[1:0], 3'b000} +: 8];
    assign ld_half = ld_word[{i_stage0.offset[1], 4'b0000} +: 16];

    always_comb begin
        case (func)
            LSU_FUNC_LB:  load_data = {{24{ld_byte[7]}}, ld_byte};
            LSU_FUNC_LBU: load_data = {24'b0, ld_byte};
            LSU_FUNC_LH:  load_data = {{16{ld_half[15]}}, ld_half};
            LSU_FUNC_LHU: load_data = {16'b0, ld_half};
            default:      load_data = ld_word;
        endcase
    end

    // Stage 0 already placed the bytes and mask, so store and fill share one write
    always_comb begin
        wr_d.en    = i_stage0.valid && (i_stage0.fill || (i_stage0.store && hit));
        wr_d.index = i_stage0.index;
        wr_d.valid = 1'b1;
        wr_d.dirty = i_stage0.fill ? i_stage0.dirty : 1'b1;
        wr_d.tag   = i_stage0.tag;
        wr_d.data  = i_stage0.data;
        wr_d.be    = i_stage0.be;
    end

    assign victim_valid = i_stage0.valid && i_stage0.fill && eff_valid;

    always_comb begin
        resp_d.valid        = i_stage0.valid;
        resp_d.hit          = i_stage0.valid && hit;
        resp_d.data         = (i_stage0.valid && is_load && hit) ? load_data : '0;
        resp_d.victim.valid = victim_valid;
        resp_d.victim.dirty = victim_valid && eff_dirty;
        // The victim address is the old tag and the index with a zero offset
        resp_d.victim.addr  = victim_valid ?
                              {eff_tag, i_stage0.index, {DC_OFFSET_WIDTH{1'b0}}} : '0;
        resp_d.victim.data  = victim_valid ? eff_data : '0;
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_cache_wr <= '0;
            o_resp     <= '0;
        end else begin
            o_cache_wr <= wr_d;
            o_resp     <= resp_d;
        end
    end

    a_wr_from_valid: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_cache_wr.en |-> $past(i_stage0.valid))
        else $error("Cache write without a valid request");

    a_hit_needs_valid: assert property (@(posedge clk) disable iff (!i_rst_n)
        !o_resp.valid |-> !o_resp.hit)
        else $error("Response hit set on an idle cycle");

endmodule

// File: rtl/dcache_defines.svh
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// Data cache geometry
// Widths are in bits and sizes are in bytes

// Load/store word width
`define DC_DATA_WIDTH 32

// Physical address width
`define DC_ADDR_WIDTH 32

// Total capacity of the single way
`define DC_CACHE_SIZE 1024

// Cache line size
`define DC_LINE_SIZE 32

`endif

// File: rtl/dcache_tag_ram.sv
`timescale 1ns/1ps

module dcache_tag_ram import dcache_types_pkg::*; (
    input  logic         clk,
    input  logic         i_rst_n,
    input  dc_index_t    i_rd_index,
    input  dc_cache_wr_t i_wr,
    output dc_cache_rd_t o_rd
);

    logic [DC_NUM_LINES-1:0] valid_q;
    logic [DC_NUM_LINES-1:0] dirty_q;
    dc_tag_t                 tag_mem [DC_NUM_LINES];
    dc_line_t                line_mem [DC_NUM_LINES];
    dc_line_t                wr_line;
    logic                    wr_fwd;
    logic                    rd_valid_q;
    logic                    rd_dirty_q;
    dc_tag_t                 rd_tag_q;
    dc_line_t                rd_data_q;

    assign wr_line = dc_merge_line(line_mem[i_wr.index], i_wr.data, i_wr.be);
    assign wr_fwd  = i_wr.en && (i_wr.index == i_rd_index);

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            valid_q    <= '0;
            dirty_q    <= '0;
            rd_valid_q <= 1'b0;
            rd_dirty_q <= 1'b0;
        end else begin
            if (i_wr.en) begin
                valid_q[i_wr.index] <= i_wr.valid;
                dirty_q[i_wr.index] <= i_wr.dirty;
            end
            rd_valid_q <= wr_fwd ? i_wr.valid : valid_q[i_rd_index];
            rd_dirty_q <= wr_fwd ? i_wr.dirty : dirty_q[i_rd_index];
        end
    end

    // A write-first read of the line being written returns the new contents
    always_ff @(posedge clk) begin
        if (i_wr.en) begin
            tag_mem[i_wr.index]  <= i_wr.tag;
            line_mem[i_wr.index] <= wr_line;
        end
        rd_tag_q  <= wr_fwd ? i_wr.tag : tag_mem[i_rd_index];
        rd_data_q <= wr_fwd ? wr_line : line_mem[i_rd_index];
    end

    assign o_rd.valid = rd_valid_q;
    assign o_rd.dirty = rd_dirty_q;
    assign o_rd.tag   = rd_tag_q;
    assign o_rd.data  = rd_data_q;

    a_hold_without_write: assert property (@(posedge clk) disable iff (!i_rst_n)
        !i_wr.en |=> $stable(valid_q) && $stable(dirty_q) &&
                     (tag_mem[$past(i_wr.index)] === $past(tag_mem[i_wr.index])))
        else $error("Line state or tag changed with no write");

endmodule

// File: rtl/dcache_types_pkg.sv
`include "dcache_defines.svh"

package dcache_types_pkg;

    localparam int DC_OFFSET_WIDTH = $clog2(`DC_LINE_SIZE);
    localparam int DC_NUM_LINES    = `DC_CACHE_SIZE / `DC_LINE_SIZE;
    localparam int DC_INDEX_WIDTH  = $clog2(DC_NUM_LINES);
    localparam int DC_TAG_WIDTH    = `DC_ADDR_WIDTH - DC_INDEX_WIDTH - DC_OFFSET_WIDTH;
    localparam int DC_LINE_BYTES   = `DC_LINE_SIZE;
    localparam int DC_LINE_WIDTH   = `DC_LINE_SIZE * 8;
    localparam int DC_WORD_BYTES   = `DC_DATA_WIDTH / 8;
    localparam int DC_LINE_WORDS   = `DC_LINE_SIZE / DC_WORD_BYTES;

    typedef logic [`DC_ADDR_WIDTH-1:0]  dc_addr_t;
    typedef logic [`DC_DATA_WIDTH-1:0]  dc_word_t;
    typedef logic [DC_TAG_WIDTH-1:0]    dc_tag_t;
    typedef logic [DC_INDEX_WIDTH-1:0]  dc_index_t;
    typedef logic [DC_OFFSET_WIDTH-1:0] dc_offset_t;
    typedef logic [DC_LINE_WIDTH-1:0]   dc_line_t;
    typedef logic [DC_LINE_BYTES-1:0]   dc_line_be_t;

    // Raw encoding of the LSU function as it travels down the pipeline
    typedef logic [2:0] dc_func_t;

    typedef struct packed {
        logic        valid;
        logic        store;
        logic        fill;
        dc_func_t    func;
        dc_tag_t     tag;
        dc_index_t   index;
        dc_offset_t  offset;
        dc_line_t    data;
        dc_line_be_t be;
        logic        dirty;
    } dc_stage0_t;

    typedef struct packed {
        logic     valid;
        logic     dirty;
        dc_tag_t  tag;
        dc_line_t data;
    } dc_cache_rd_t;

    typedef struct packed {
        logic        en;
        dc_index_t   index;
        logic        valid;
        logic        dirty;
        dc_tag_t     tag;
        dc_line_t    data;
        dc_line_be_t be;
    } dc_cache_wr_t;

    typedef struct packed {
        logic     valid;
        logic     dirty;
        dc_addr_t addr;
        dc_line_t data;
    } dc_victim_t;

    // Overlay the enabled bytes of wdata on base
    function automatic dc_line_t dc_merge_line(dc_line_t base, dc_line_t wdata, dc_line_be_t be);
        dc_line_t merged;
        merged = base;
        for (int b = 0; b < DC_LINE_BYTES; b++) begin
            if (be[b]) begin
                merged[b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
        return merged;
    endfunction

endpackage

// File: rtl/lsu_pkg.sv
package lsu_pkg;

    import dcache_types_pkg::*;

    // Loads first, then stores
    typedef enum logic [2:0] {
        LSU_FUNC_LB  = 3'd0,
        LSU_FUNC_LH  = 3'd1,
        LSU_FUNC_LW  = 3'd2,
        LSU_FUNC_LBU = 3'd3,
        LSU_FUNC_LHU = 3'd4,
        LSU_FUNC_SB  = 3'd5,
        LSU_FUNC_SH  = 3'd6,
        LSU_FUNC_SW  = 3'd7
    } lsu_func_e;

    typedef struct packed {
        logic      valid;
        logic      fill;
        lsu_func_e func;
        dc_addr_t  addr;
        dc_word_t  data;
        dc_line_t  fill_data;
        logic      fill_dirty;
    } dc_req_t;

    typedef struct packed {
        logic       valid;
        logic       hit;
        dc_word_t   data;
        dc_victim_t victim;
    } dc_resp_t;

endpackage

// File: src.f
+incdir+rtl
rtl/dcache_types_pkg.sv
rtl/lsu_pkg.sv
rtl/dcache_tag_ram.sv
rtl/dcache_d0.sv
rtl/dcache_d1.sv
rtl/dcache.sv
tb/tb_clk_gen.sv
tb/dcache_tb.sv

// File: tb/dcache_tb.sv
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_tb import dcache_types_pkg::*, lsu_pkg::*; ();

    localparam int NUM_LINES   = `DC_CACHE_SIZE / `DC_LINE_SIZE;
    localparam int RANDOM_OPS  = 3000;
    localparam int DRAIN_LIMIT = 16;
    localparam int WATCHDOG_NS = 200000;

    logic      clk;
    logic      i_rst_n;
    dc_req_t   i_req;
    dc_resp_t  o_resp;

    // Reference cache, one entry per line
    logic      m_valid [NUM_LINES];
    logic      m_dirty [NUM_LINES];
    dc_tag_t   m_tag   [NUM_LINES];
    dc_line_t  m_line  [NUM_LINES];

    dc_resp_t  exp_q [$];
    dc_tag_t   tag_pool [4];
    dc_index_t last_index;
    int        errors;
    int        checks;

    tb_clk_gen u_clk_gen (
        .o_clk (clk)
    );

    dcache u_dut (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_req   (i_req),
        .o_resp  (o_resp)
    );

    function automatic logic is_store(lsu_func_e f);
        return (f == LSU_FUNC_SB) || (f == LSU_FUNC_SH) || (f == LSU_FUNC_SW);
    endfunction

    function automatic int access_bytes(lsu_func_e f);
        case (f)
            LSU_FUNC_LB, LSU_FUNC_LBU, LSU_FUNC_SB: return 1;
            LSU_FUNC_LH, LSU_FUNC_LHU, LSU_FUNC_SH: return 2;
            default: return 4;
        endcase
    endfunction

    function automatic lsu_func_e load_func(logic [2:0] sel);
        case (sel)
            3'd0, 3'd5: return LSU_FUNC_LB;
            3'd1, 3'd6: return LSU_FUNC_LH;
            3'd2:       return LSU_FUNC_LW;
            3'd3, 3'd7: return LSU_FUNC_LBU;
            default:    return LSU_FUNC_LHU;
        endcase
    endfunction

    function automatic lsu_func_e store_func(logic [1:0] sel);
        case (sel)
            2'd0:    return LSU_FUNC_SB;
            2'd1:    return LSU_FUNC_SH;
            default: return LSU_FUNC_SW;
        endcase
    endfunction

    // Little-endian bytes from the line, then sign extension for LB and LH
    function automatic dc_word_t load_value(dc_line_t line, lsu_func_e f, int off);
        dc_word_t raw;
        raw = '0;
        for (int i = 0; i < access_bytes(f); i++) begin
            raw[i*8 +: 8] = line[(off + i) * 8 +: 8];
        end
        if (f == LSU_FUNC_LB && raw[7]) begin
            raw[31:8] = '1;
        end
        if (f == LSU_FUNC_LH && raw[15]) begin
            raw[31:16] = '1;
        end
        return raw;
    endfunction

    // Expected response of one request, applied to the model in program order
    function automatic dc_resp_t model_step(dc_req_t r);
        dc_resp_t   e;
        dc_tag_t    tag;
        dc_index_t  idx;
        dc_offset_t off;
        logic       hit;
        e = '0;
        if (!r.valid) begin
            return e;
        end
        {tag, idx, off} = r.addr;
        hit     = m_valid[idx] && (m_tag[idx] == tag);
        e.valid = 1'b1;
        e.hit   = hit;
        if (r.fill) begin
            if (m_valid[idx]) begin
                e.victim.valid = 1'b1;
                e.victim.dirty = m_dirty[idx];
                e.victim.addr  = {m_tag[idx], idx, dc_offset_t'(0)};
                e.victim.data  = m_line[idx];
            end
            m_valid[idx] = 1'b1;
            m_dirty[idx] = r.fill_dirty;
            m_tag[idx]   = tag;
            m_line[idx]  = r.fill_data;
        end else if (is_store(r.func)) begin
            if (hit) begin
                for (int i = 0; i < access_bytes(r.func); i++) begin
                    m_line[idx][(int'(off) + i) * 8 +: 8] = r.data[i*8 +: 8];
                end
                m_dirty[idx] = 1'b1;
            end
        end else if (hit) begin
            e.data = load_value(m_line[idx], r.func, int'(off));
        end
        return e;
    endfunction

    function automatic dc_req_t idle_req();
        dc_req_t r;
        r = '0;
        return r;
    endfunction

    function automatic dc_req_t load_req(lsu_func_e f, dc_addr_t a);
        dc_req_t r;
        r       = '0;
        r.valid = 1'b1;
        r.func  = f;
        r.addr  = a;
        return r;
    endfunction

    function automatic dc_req_t store_req(lsu_func_e f, dc_addr_t a, dc_word_t d);
        dc_req_t r;
        r       = load_req(f, a);
        r.data  = d;
        return r;
    endfunction

    function automatic dc_req_t fill_req(dc_addr_t a, dc_line_t line, logic dirty);
        dc_req_t r;
        r            = load_req(LSU_FUNC_LW, a);
        r.fill       = 1'b1;
        r.fill_data  = line;
        r.fill_dirty = dirty;
        return r;
    endfunction

    function automatic dc_line_t random_line();
        dc_line_t l;
        for (int w = 0; w < DC_LINE_WORDS; w++) begin
            l[w*`DC_DATA_WIDTH +: `DC_DATA_WIDTH] = $urandom();
        end
        return l;
    endfunction

    // Half the time stay on the last index so same-line requests pile up
    function automatic dc_addr_t pick_addr(lsu_func_e f);
        logic [31:0] rnd;
        dc_index_t   idx;
        dc_offset_t  off;
        rnd = $urandom();
        idx = rnd[31] ? last_index : rnd[4:0];
        off = rnd[9:5];
        if (access_bytes(f) == 2) begin
            off[0] = 1'b0;
        end
        if (access_bytes(f) == 4) begin
            off[1:0] = 2'b00;
        end
        last_index = idx;
        return {tag_pool[rnd[11:10]], idx, off};
    endfunction

    function automatic int pending_requests();
        int n;
        n = 0;
        foreach (exp_q[i]) begin
            if (exp_q[i].valid) begin
                n++;
            end
        end
        return n;
    endfunction

    task automatic compare_field(string name, dc_line_t got, dc_line_t exp);
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic check_response(dc_resp_t e);
        checks++;
        compare_field("o_resp.valid", dc_line_t'(o_resp.valid), dc_line_t'(e.valid));
        compare_field("o_resp.hit", dc_line_t'(o_resp.hit), dc_line_t'(e.hit));
        compare_field("o_resp.data", dc_line_t'(o_resp.data), dc_line_t'(e.data));
        compare_field("o_resp.victim.valid", dc_line_t'(o_resp.victim.valid),
                      dc_line_t'(e.victim.valid));
        compare_field("o_resp.victim.dirty", dc_line_t'(o_resp.victim.dirty),
                      dc_line_t'(e.victim.dirty));
        compare_field("o_resp.victim.addr", dc_line_t'(o_resp.victim.addr),
                      dc_line_t'(e.victim.addr));
        compare_field("o_resp.victim.data", o_resp.victim.data, e.victim.data);
    endtask

    // The response to a request driven two rising edges ago is settled by the falling edge
    task automatic issue(dc_req_t r);
        @(posedge clk);
        i_req <= r;
        exp_q.push_back(model_step(r));
        @(negedge clk);
        if (exp_q.size() > 2) begin
            check_response(exp_q.pop_front());
        end
    endtask

    task automatic reset_dut();
        repeat (4) begin
            @(negedge clk);
            if (o_resp.valid !== 1'b0) begin
                errors++;
                $display("Fail at %0t: o_resp.valid got %0b expected 0", $time, o_resp.valid);
            end
        end
        @(posedge clk);
        i_rst_n <= 1'b1;
        // The two cycles after reset carry no request
        exp_q.push_back('0);
        exp_q.push_back('0);
    endtask

    task automatic directed_checks();
        dc_addr_t  base;
        dc_addr_t  other;
        lsu_func_e f;
        for (int i = 0; i < NUM_LINES; i++) begin
            issue(load_req(LSU_FUNC_LW, {tag_pool[0], dc_index_t'(i), dc_offset_t'(0)}));
        end
        base = {tag_pool[1], dc_index_t'(3), dc_offset_t'(0)};
        issue(fill_req(base, random_line(), 1'b0));
        for (int o = 0; o < `DC_LINE_SIZE; o++) begin
            for (int s = 0; s < 5; s++) begin
                f = load_func(3'(s));
                if (o % access_bytes(f) == 0) begin
                    issue(load_req(f, base | dc_addr_t'(o)));
                end
            end
        end
        issue(store_req(LSU_FUNC_SB, base | 32'h5, 32'h0000_00a7));
        issue(store_req(LSU_FUNC_SH, base | 32'ha, 32'h0000_8123));
        issue(store_req(LSU_FUNC_SW, base | 32'h10, 32'hdead_beef));
        for (int o = 0; o < 24; o += 4) begin
            issue(load_req(LSU_FUNC_LW, base | dc_addr_t'(o)));
        end
        // Store to a different tag on the same line must leave it alone
        other = {tag_pool[2], dc_index_t'(3), dc_offset_t'(4)};
        issue(store_req(LSU_FUNC_SW, other, 32'h1234_5678));
        issue(load_req(LSU_FUNC_LW, other));
        issue(load_req(LSU_FUNC_LW, base | 32'h4));
        issue(fill_req(other, random_line(), 1'b0));
        issue(fill_req({tag_pool[3], dc_index_t'(3), dc_offset_t'(0)}, random_line(), 1'b1));
        issue(fill_req(base, random_line(), 1'b0));
        base = {tag_pool[0], dc_index_t'(7), dc_offset_t'(0)};
        issue(fill_req(base, random_line(), 1'b0));
        issue(store_req(LSU_FUNC_SB, base | 32'h1, 32'h0000_005a));
        issue(load_req(LSU_FUNC_LW, base));
        issue(store_req(LSU_FUNC_SH, base | 32'h2, 32'h0000_c3c3));
        issue(idle_req());
        issue(load_req(LSU_FUNC_LW, base));
        issue(fill_req({tag_pool[1], dc_index_t'(7), dc_offset_t'(0)}, random_line(), 1'b1));
        issue(load_req(LSU_FUNC_LBU, {tag_pool[1], dc_index_t'(7), dc_offset_t'(0)}));
    endtask

    task automatic random_run(int count);
        logic [31:0] rnd;
        lsu_func_e   f;
        for (int n = 0; n < count; n++) begin
            rnd = $urandom();
            if (rnd[3:0] < 4'd2) begin
                issue(idle_req());
            end else if (rnd[3:0] < 4'd5) begin
                issue(fill_req(pick_addr(LSU_FUNC_LW), random_line(), rnd[7]));
            end else if (rnd[3:0] < 4'd10) begin
                f = store_func(rnd[5:4]);
                issue(store_req(f, pick_addr(f), $urandom()));
            end else begin
                f = load_func(rnd[6:4]);
                issue(load_req(f, pick_addr(f)));
            end
        end
    endtask

    task automatic drain_pipeline();
        int guard;
        guard = 0;
        while (pending_requests() > 0 && guard < DRAIN_LIMIT) begin
            issue(idle_req());
            guard++;
        end
        if (pending_requests() > 0) begin
            errors++;
            $display("Timeout: responses still outstanding after %0d idle cycles", guard);
        end
    endtask

    initial begin
        i_rst_n    = 1'b0;
        i_req      = '0;
        errors     = 0;
        checks     = 0;
        last_index = '0;
        void'($urandom(32'hce67_506c));
        tag_pool[0] = 22'h0_00a5;
        tag_pool[1] = 22'h3_c1e0;
        tag_pool[2] = 22'h1_2345;
        tag_pool[3] = 22'h2_0f0f;
        for (int i = 0; i < NUM_LINES; i++) begin
            m_valid[i] = 1'b0;
            m_dirty[i] = 1'b0;
            m_tag[i]   = '0;
            m_line[i]  = '0;
        end
        reset_dut();
        directed_checks();
        random_run(RANDOM_OPS);
        drain_pipeline();
        $display("Checked %0d responses, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: simulation ran past %0d ns", WATCHDOG_NS);
        $display("Test failures found");
        $finish;
    end

endmodule

// File: tb/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
    output logic o_clk
);

    // The clock starts low and toggles every 4 ns
    initial begin
        o_clk = 1'b0;
        forever begin
            #4 o_clk = ~o_clk;
        end
    end

endmodule
